// ==== project.f ====
+incdir+include
design/mont_ctrl_pkg.sv
design/mont_host_pkg.sv
design/mont_operand_store.sv
design/mont_pe_first.sv
design/mont_pe_word.sv
design/mont_sequencer.sv
design/mont_top.sv
verif/tb_mont.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mont
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_mont.sv ====
// Testbench for the Montgomery modular multiplier
// Directed tests against a 128-bit reference rule, fixed-latency and lockout checks
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module tb_mont import mont_host_pkg::*;;

    localparam int R     = `MONT_RADIX;
    localparam int NW    = `MONT_NUM_WORDS;
    localparam int IDX_W = `MONT_IDX_W;
    localparam int OP_W  = R * NW;
    // Rows then subtraction and store then the done cycle
    localparam int EXPECTED_LATENCY = NW * (NW + 1) + 2 * NW + 1;
    localparam int DONE_LIMIT       = 4 * EXPECTED_LATENCY;
    // Budget for one run with operand load and readback
    localparam int MULT_CYCLES      = 80;
    localparam int TIMEOUT_CYCLES   = 40 * MULT_CYCLES;

    logic               clk;
    logic               reset_n;
    logic               wr_en_i;
    operand_sel_e       wr_sel_i;
    logic [IDX_W-1:0]   wr_idx_i;
    word_t              wr_data_i;
    logic [IDX_W-1:0]   rd_idx_i;
    word_t              rd_data_o;
    logic               start_i;
    logic               busy_o;
    logic               done_o;

    logic [31:0]        rng_state;
    int                 cycle_count;

    mont_top i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_en_i   (wr_en_i),
        .wr_sel_i  (wr_sel_i),
        .wr_idx_i  (wr_idx_i),
        .wr_data_i (wr_data_i),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (rd_data_o),
        .start_i   (start_i),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [OP_W-1:0] rand_operand();
        logic [OP_W-1:0] v;
        v = '0;
        for (int i = 0; i < OP_W; i += 32) begin
            v = (v << 32) | OP_W'(next_rand());
        end
        return v;
    endfunction

    // Newton iteration x = x*(2 - p*x) doubles the correct low bits
    function automatic word_t calc_n_prime(input word_t p0);
        word_t x;
        x = p0;
        for (int i = 0; i < 5; i++) begin
            x = x * (word_t'(2) - p0 * x);
        end
        return word_t'(0) - x;
    endfunction

    task automatic write_word(input operand_sel_e sel, input int idx, input word_t data);
        @(posedge clk);
        #2;
        wr_en_i   = 1'b1;
        wr_sel_i  = sel;
        wr_idx_i  = IDX_W'(idx);
        wr_data_i = data;
    endtask

    task automatic write_operands(input logic [OP_W-1:0] a, b, p);
        for (int i = 0; i < NW; i++) begin
            write_word(SEL_A, i, a[i*R +: R]);
            write_word(SEL_B, i, b[i*R +: R]);
            write_word(SEL_P, i, p[i*R +: R]);
        end
        write_word(SEL_NPRIME, 0, calc_n_prime(p[R-1:0]));
        @(posedge clk);
        #2;
        wr_en_i = 1'b0;
    endtask

    // Optional poke issues a second start and a write to A's top word mid-run
    task automatic run_mult(input logic poke, input word_t poke_word, output int latency);
        int cycles;
        @(posedge clk);
        #2;
        start_i = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            #2;
            start_i = 1'b0;
            wr_en_i = 1'b0;
            cycles++;
            if (!done_o) begin
                assert (busy_o) else stop_on_error($sformatf(
                    "MISMATCH at %0t: busy_o low %0d cycles into a run", $time, cycles));
            end
            if (poke && cycles == 5) begin
                start_i   = 1'b1;
                wr_en_i   = 1'b1;
                wr_sel_i  = SEL_A;
                wr_idx_i  = IDX_W'(NW - 1);
                wr_data_i = poke_word;
            end
            if (cycles > DONE_LIMIT) begin
                stop_on_error("ERROR: done_o never arrived after start_i");
            end
        end while (!done_o);
        latency = cycles;
    endtask

    task automatic read_result(output logic [OP_W-1:0] r);
        r = '0;
        for (int i = 0; i < NW; i++) begin
            @(posedge clk);
            #2;
            rd_idx_i = IDX_W'(i);
            #10;
            r[i*R +: R] = rd_data_o;
        end
    endtask

    // r is right when r < P and r*2^OP_W == A*B mod P
    task automatic check_result(input logic [OP_W-1:0] a, b, p, output logic [OP_W-1:0] r);
        logic [2*OP_W-1:0] lhs;
        logic [2*OP_W-1:0] rhs;
        logic [2*OP_W-1:0] p_wide;
        read_result(r);
        p_wide = {{OP_W{1'b0}}, p};
        lhs    = {r, {OP_W{1'b0}}} % p_wide;
        rhs    = ({{OP_W{1'b0}}, a} * {{OP_W{1'b0}}, b}) % p_wide;
        assert (r < p) else stop_on_error($sformatf(
            "MISMATCH at %0t: result %h is not below P %h", $time, r, p));
        assert (lhs == rhs) else stop_on_error($sformatf(
            "MISMATCH at %0t: A %h B %h P %h gave %h, r*R mod P %h vs A*B mod P %h",
            $time, a, b, p, r, lhs, rhs));
    endtask

    task automatic multiply(input logic [OP_W-1:0] a, b, p,
                            output logic [OP_W-1:0] r, output int latency);
        write_operands(a, b, p);
        run_mult(1'b0, '0, latency);
        check_result(a, b, p, r);
    endtask

    function automatic logic [OP_W-1:0] rand_modulus();
        return rand_operand() | {1'b1, {(OP_W-2){1'b0}}, 1'b1};
    endfunction

    //--------------------------------------------------
    // Tests
    //--------------------------------------------------

    task automatic test_reset_state();
        logic [OP_W-1:0] r;
        assert (!busy_o && !done_o) else stop_on_error($sformatf(
            "MISMATCH at %0t: busy_o %b done_o %b after reset", $time, busy_o, done_o));
        read_result(r);
        assert (r == '0) else stop_on_error($sformatf(
            "MISMATCH at %0t: result %h after reset, expected zero", $time, r));
    endtask

    task automatic test_edge_operands();
        logic [OP_W-1:0] p;
        logic [OP_W-1:0] r;
        int              latency;
        p = rand_modulus();
        multiply('0, rand_operand() % p, p, r, latency);
        assert (r == '0) else stop_on_error($sformatf(
            "MISMATCH at %0t: A = 0 gave %h", $time, r));
        // Gives R-inverse mod P
        multiply(OP_W'(1), OP_W'(1), p, r, latency);
    endtask

    task automatic test_random_operands();
        logic [OP_W-1:0] a;
        logic [OP_W-1:0] b;
        logic [OP_W-1:0] p;
        logic [OP_W-1:0] r;
        int              latency;
        for (int n = 0; n < 25; n++) begin
            p = rand_modulus();
            a = rand_operand() % p;
            b = rand_operand() % p;
            multiply(a, b, p, r, latency);
            assert (latency == EXPECTED_LATENCY) else stop_on_error($sformatf(
                "MISMATCH at %0t: latency %0d, expected %0d", $time, latency,
                EXPECTED_LATENCY));
        end
    endtask

    // Largest prime below 2^64 leaves scratch above P before the subtraction
    task automatic test_final_subtraction();
        logic [OP_W-1:0] p;
        logic [OP_W-1:0] r;
        int              latency;
        p = {OP_W{1'b1}} - OP_W'(58);
        multiply(p - OP_W'(1), p - OP_W'(1), p, r, latency);
    endtask

    task automatic test_busy_lockout();
        logic [OP_W-1:0] a;
        logic [OP_W-1:0] b;
        logic [OP_W-1:0] p;
        logic [OP_W-1:0] r;
        int              latency;
        int              extra_done;
        p = rand_modulus();
        a = rand_operand() % p;
        b = rand_operand() % p;
        write_operands(a, b, p);
        run_mult(1'b1, ~a[OP_W-1 -: R], latency);
        // A restart on the second strobe would stretch the latency
        assert (latency == EXPECTED_LATENCY) else stop_on_error($sformatf(
            "MISMATCH at %0t: latency %0d with a start while busy, expected %0d",
            $time, latency, EXPECTED_LATENCY));
        extra_done = 0;
        repeat (2 * EXPECTED_LATENCY) begin
            @(posedge clk);
            #2;
            if (done_o) begin
                extra_done++;
            end
        end
        assert (extra_done == 0) else stop_on_error($sformatf(
            "MISMATCH at %0t: %0d extra done_o pulses after one start", $time, extra_done));
        check_result(a, b, p, r);
        // Store still takes new operands once idle
        p = rand_modulus();
        a = rand_operand() % p;
        b = rand_operand() % p;
        multiply(a, b, p, r, latency);
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        wr_en_i      = 1'b0;
        wr_sel_i     = SEL_A;
        wr_idx_i     = '0;
        wr_data_i    = '0;
        rd_idx_i     = '0;
        start_i      = 1'b0;
        rng_state    = 32'ha556fa9a;
        cycle_count  = 0;

        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        test_reset_state();
        test_edge_operands();
        test_random_operands();
        test_final_subtraction();
        test_busy_lockout();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mont_top.sv ====
// Montgomery modular multiplier top level
// Connects the operand store, both processing elements and the sequencer
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module mont_top import mont_ctrl_pkg::*, mont_host_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_n,
    // Host write port
    input  wire                     wr_en_i,
    input  operand_sel_e            wr_sel_i,
    input  wire [`MONT_IDX_W-1:0]   wr_idx_i,
    input  word_t                   wr_data_i,
    // Host read port
    input  wire [`MONT_IDX_W-1:0]   rd_idx_i,
    output word_t                   rd_data_o,
    // Control
    input  wire                     start_i,
    output logic                    busy_o,
    output logic                    done_o
);

    // Store to datapath
    logic [`MONT_IDX_W-1:0] row_idx;
    logic [`MONT_IDX_W-1:0] word_idx;
    word_t                  a_word;
    word_t                  b_word;
    word_t                  p_word;
    word_t                  n_prime;

    // Element handshake with the sequencer
    logic                   row_start;
    word_t                  m_word;
    carry_t                 first_carry;
    word_t                  scratch_word;
    carry_t                 pe_carry;
    word_t                  word_sum;
    carry_t                 word_carry;

    // Result path
    logic                   res_we;
    logic [`MONT_IDX_W-1:0] res_idx;
    word_t                  res_data;

    mont_operand_store u_store (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_en_i    (wr_en_i),
        .wr_sel_i   (wr_sel_i),
        .wr_idx_i   (wr_idx_i),
        .wr_data_i  (wr_data_i),
        .lock_i     (busy_o),
        .a_idx_i    (row_idx),
        .bp_idx_i   (word_idx),
        .a_word_o   (a_word),
        .b_word_o   (b_word),
        .p_word_o   (p_word),
        .n_prime_o  (n_prime),
        .res_we_i   (res_we),
        .res_idx_i  (res_idx),
        .res_data_i (res_data),
        .rd_idx_i   (rd_idx_i),
        .rd_data_o  (rd_data_o)
    );

    mont_pe_first u_pe_first (
        .clk         (clk),
        .reset_n     (reset_n),
        .row_start_i (row_start),
        .s0_i        (scratch_word),
        .a_i         (a_word),
        .b0_i        (b_word),
        .p0_i        (p_word),
        .n_prime_i   (n_prime),
        .m_o         (m_word),
        .carry_o     (first_carry)
    );

    mont_pe_word u_pe_word (
        .s_i     (scratch_word),
        .a_i     (a_word),
        .b_i     (b_word),
        .m_i     (m_word),
        .p_i     (p_word),
        .carry_i (pe_carry),
        .sum_o   (word_sum),
        .carry_o (word_carry)
    );

    mont_sequencer u_seq (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .row_idx_o      (row_idx),
        .word_idx_o     (word_idx),
        .p_word_i       (p_word),
        .row_start_o    (row_start),
        .first_carry_i  (first_carry),
        .word_sum_i     (word_sum),
        .word_carry_i   (word_carry),
        .scratch_word_o (scratch_word),
        .carry_o        (pe_carry),
        .res_we_o       (res_we),
        .res_idx_o      (res_idx),
        .res_data_o     (res_data)
    );

endmodule

`default_nettype wire

// ==== design/mont_sequencer.sv ====
// Montgomery multiplier sequencer
// Runs the CIOS rows, the final subtraction of P and the result store
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module mont_sequencer import mont_ctrl_pkg::*, mont_host_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_n,
    // Host control
    input  wire                     start_i,
    output logic                    busy_o,
    output logic                    done_o,
    // Operand store addressing
    output logic [`MONT_IDX_W-1:0]  row_idx_o,
    output logic [`MONT_IDX_W-1:0]  word_idx_o,
    input  word_t                   p_word_i,
    // Processing element interface
    output logic                    row_start_o,
    input  carry_t                  first_carry_i,
    input  word_t                   word_sum_i,
    input  carry_t                  word_carry_i,
    output word_t                   scratch_word_o,
    output carry_t                  carry_o,
    // Result writes into the store
    output logic                    res_we_o,
    output logic [`MONT_IDX_W-1:0]  res_idx_o,
    output word_t                   res_data_o
);

    localparam int R     = `MONT_RADIX;
    localparam int NW    = `MONT_NUM_WORDS;
    localparam int IDX_W = `MONT_IDX_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NW - 1);
    localparam logic [IDX_W-1:0] ONE_IDX  = IDX_W'(1);

    seq_state_e         state_q;
    logic [IDX_W-1:0]   row_q;
    logic [IDX_W-1:0]   word_q;
    logic [IDX_W-1:0]   prev_idx;

    // Scratch accumulator, NW words plus one top bit
    word_t              scratch_q [NW];
    logic               top_q;
    carry_t             carry_q;

    // Difference words and borrow of scratch minus P
    word_t              diff_q [NW];
    logic               borrow_q;

    logic [R:0]         sub_full;
    carry_t             top_sum;
    logic               use_diff;

    //--------------------------------------------------
    // Datapath helpers
    //--------------------------------------------------

    assign prev_idx = word_q - ONE_IDX;

    // Word 1 takes the carry straight from the first element
    assign carry_o = (word_q == ONE_IDX) ? first_carry_i : carry_q;

    // Row end folds the last carry into the top word
    assign top_sum = carry_q + {{R{1'b0}}, top_q};

    // One word of scratch minus P, bit R is the borrow out
    assign sub_full = {1'b0, scratch_q[word_q]} - {1'b0, p_word_i} - {{R{1'b0}}, borrow_q};

    // Subtract when scratch >= P or scratch overflowed into the top bit
    assign use_diff = !borrow_q || top_q;

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= ST_IDLE;
            row_q    <= '0;
            word_q   <= '0;
            carry_q  <= '0;
            top_q    <= 1'b0;
            borrow_q <= 1'b0;
            for (int i = 0; i < NW; i++) begin
                scratch_q[i] <= '0;
            end
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_FIRST;
                        row_q   <= '0;
                        word_q  <= '0;
                        top_q   <= 1'b0;
                        // Fresh accumulator for every run
                        for (int i = 0; i < NW; i++) begin
                            scratch_q[i] <= '0;
                        end
                    end
                end
                ST_FIRST: begin
                    // First element captures m and carry at this edge
                    state_q <= ST_WORD;
                    word_q  <= ONE_IDX;
                end
                ST_WORD: begin
                    // Writing word j-1 performs the row shift
                    scratch_q[prev_idx] <= word_sum_i;
                    carry_q             <= word_carry_i;
                    if (word_q == LAST_IDX) begin
                        state_q <= ST_TOP;
                    end else begin
                        word_q <= word_q + ONE_IDX;
                    end
                end
                ST_TOP: begin
                    {top_q, scratch_q[LAST_IDX]} <= top_sum;
                    word_q <= '0;
                    if (row_q == LAST_IDX) begin
                        state_q  <= ST_SUB;
                        borrow_q <= 1'b0;
                    end else begin
                        state_q <= ST_FIRST;
                        row_q   <= row_q + ONE_IDX;
                    end
                end
                ST_SUB: begin
                    borrow_q <= sub_full[R];
                    if (word_q == LAST_IDX) begin
                        state_q <= ST_STORE;
                        word_q  <= '0;
                    end else begin
                        word_q <= word_q + ONE_IDX;
                    end
                end
                ST_STORE: begin
                    if (word_q == LAST_IDX) begin
                        state_q <= ST_DONE;
                    end else begin
                        word_q <= word_q + ONE_IDX;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Difference words, one per subtraction cycle
    always_ff @(posedge clk) begin
        if (state_q == ST_SUB) begin
            diff_q[word_q] <= sub_full[R-1:0];
        end
    end

    //--------------------------------------------------
    // Outputs
    //--------------------------------------------------

    assign busy_o      = (state_q != ST_IDLE);
    assign done_o      = (state_q == ST_DONE);
    assign row_start_o = (state_q == ST_FIRST);

    assign row_idx_o      = row_q;
    assign word_idx_o     = word_q;
    assign scratch_word_o = scratch_q[word_q];

    // Result streams out word by word in ST_STORE
    assign res_we_o   = (state_q == ST_STORE);
    assign res_idx_o  = word_q;
    assign res_data_o = use_diff ? diff_q[word_q] : scratch_q[word_q];

endmodule

`default_nettype wire

// ==== design/mont_pe_word.sv ====
// General word element of a Montgomery row
// Forms s + a*b + m*p + carry and splits it into a word and a carry
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module mont_pe_word import mont_ctrl_pkg::*, mont_host_pkg::*; (
    input  word_t   s_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  word_t   m_i,
    input  word_t   p_i,
    input  carry_t  carry_i,
    output word_t   sum_o,
    output carry_t  carry_o
);

    localparam int R = `MONT_RADIX;

    logic [2*R-1:0] prod_ab;
    logic [2*R-1:0] prod_mp;
    logic [2*R:0]   word_sum;

    assign prod_ab = a_i * b_i;
    assign prod_mp = m_i * p_i;

    // Worst case is 2*W^2 - W, one bit above two words
    assign word_sum = {1'b0, prod_ab}
                    + {1'b0, prod_mp}
                    + {{(R+1){1'b0}}, s_i}
                    + {{R{1'b0}}, carry_i};

    // Low word goes back to scratch, high part rides to the next word
    assign sum_o   = word_sum[R-1:0];
    assign carry_o = word_sum[2*R:R];

endmodule

`default_nettype wire

// ==== design/mont_pe_first.sv ====
// First processing element for word 0 of a Montgomery row
// Derives the row reduction factor m and the first carry, registered
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module mont_pe_first import mont_ctrl_pkg::*, mont_host_pkg::*; (
    input  wire     clk,
    input  wire     reset_n,
    input  wire     row_start_i,
    // Word 0 operands of the current row
    input  word_t   s0_i,
    input  word_t   a_i,
    input  word_t   b0_i,
    input  word_t   p0_i,
    input  word_t   n_prime_i,
    // Row factor and carry into word 1
    output word_t   m_o,
    output carry_t  carry_o
);

    localparam int R = `MONT_RADIX;

    logic [2*R-1:0] prod_ab;
    logic [2*R-1:0] t_sum;
    word_t          m_next;
    logic [2*R-1:0] prod_mp;
    logic [2*R:0]   row_sum;

    //--------------------------------------------------
    // Word 0 datapath
    //--------------------------------------------------

    // s0 + a*b0 stays below W^2, no extra bit
    assign prod_ab = a_i * b0_i;
    assign t_sum   = prod_ab + {{R{1'b0}}, s0_i};

    // m = t mod W times N_PRIME mod W
    assign m_next = t_sum[R-1:0] * n_prime_i;

    assign prod_mp = m_next * p0_i;

    // Low word of this sum is zero by choice of m
    assign row_sum = {1'b0, t_sum} + {1'b0, prod_mp};

    //--------------------------------------------------
    // Output registers
    //--------------------------------------------------

    // Loaded once per row, held for the word cycles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            m_o     <= '0;
            carry_o <= '0;
        end else if (row_start_i) begin
            m_o     <= m_next;
            carry_o <= row_sum[2*R:R];
        end
    end

endmodule

`default_nettype wire

// ==== design/mont_operand_store.sv ====
// Operand store for A, B, P, N_PRIME and the result words
// Host write port locked while busy, combinational reads
`default_nettype none
`timescale 1ns/1ps

`include "mont_settings.svh"

module mont_operand_store import mont_host_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_n,
    // Host write port
    input  wire                     wr_en_i,
    input  operand_sel_e            wr_sel_i,
    input  wire [`MONT_IDX_W-1:0]   wr_idx_i,
    input  word_t                   wr_data_i,
    input  wire                     lock_i,
    // Sequencer operand reads
    input  wire [`MONT_IDX_W-1:0]   a_idx_i,
    input  wire [`MONT_IDX_W-1:0]   bp_idx_i,
    output word_t                   a_word_o,
    output word_t                   b_word_o,
    output word_t                   p_word_o,
    output word_t                   n_prime_o,
    // Sequencer result writes
    input  wire                     res_we_i,
    input  wire [`MONT_IDX_W-1:0]   res_idx_i,
    input  word_t                   res_data_i,
    // Host result read
    input  wire [`MONT_IDX_W-1:0]   rd_idx_i,
    output word_t                   rd_data_o
);

    localparam int NW = `MONT_NUM_WORDS;

    word_t a_mem   [NW];
    word_t b_mem   [NW];
    word_t p_mem   [NW];
    word_t n_prime_q;
    word_t res_mem [NW];

    // Host writes are dropped while the sequencer runs
    always_ff @(posedge clk) begin
        if (wr_en_i && !lock_i) begin
            case (wr_sel_i)
                SEL_A:      a_mem[wr_idx_i] <= wr_data_i;
                SEL_B:      b_mem[wr_idx_i] <= wr_data_i;
                SEL_P:      p_mem[wr_idx_i] <= wr_data_i;
                SEL_NPRIME: n_prime_q       <= wr_data_i;
                default: ;
            endcase
        end
    end

    // Result words read as zero after reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NW; i++) begin
                res_mem[i] <= '0;
            end
        end else if (res_we_i) begin
            res_mem[res_idx_i] <= res_data_i;
        end
    end

    // A is indexed by row, B and P by word
    assign a_word_o  = a_mem[a_idx_i];
    assign b_word_o  = b_mem[bp_idx_i];
    assign p_word_o  = p_mem[bp_idx_i];
    assign n_prime_o = n_prime_q;
    assign rd_data_o = res_mem[rd_idx_i];

endmodule

`default_nettype wire

// ==== design/mont_host_pkg.sv ====
// Montgomery multiplier host types
// Operand word type and the host write target encoding
`default_nettype none

`include "mont_settings.svh"

package mont_host_pkg;

    // One operand word
    typedef logic [`MONT_RADIX-1:0] word_t;

    // Host write target, N_PRIME ignores the word index
    typedef enum logic [1:0] {
        SEL_A      = 2'd0,
        SEL_B      = 2'd1,
        SEL_P      = 2'd2,
        SEL_NPRIME = 2'd3
    } operand_sel_e;

endpackage

`default_nettype wire

// ==== design/mont_ctrl_pkg.sv ====
// Montgomery multiplier control types
// Sequencer state encoding and the row carry type
`default_nettype none

`include "mont_settings.svh"

package mont_ctrl_pkg;

    // Sequencer states, one row is FIRST, WORD..., TOP
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_FIRST = 3'd1,
        ST_WORD  = 3'd2,
        ST_TOP   = 3'd3,
        ST_SUB   = 3'd4,
        ST_STORE = 3'd5,
        ST_DONE  = 3'd6
    } seq_state_e;

    // Row carry, high part of a 2*RADIX+1 bit word sum
    typedef logic [`MONT_RADIX:0] carry_t;

endpackage

`default_nettype wire

// ==== include/mont_settings.svh ====
// Montgomery multiplier settings
// Word width, word count and word index width shared by every block
`ifndef MONT_SETTINGS_SVH
`define MONT_SETTINGS_SVH

// Bits per operand word
`define MONT_RADIX 16

// Words per operand, 64-bit operands at the defaults
`define MONT_NUM_WORDS 4

// Index width, must cover MONT_NUM_WORDS words
`define MONT_IDX_W 2

`endif
